/* logic/isa_pkg.sv */
// architecture level types
package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // instruction addresses
    //////////////////////////////////////////////////////////////////////

    // full byte address of an instruction
    typedef logic [31:0] pc_t;

    //////////////////////////////////////////////////////////////////////
    // register naming
    //////////////////////////////////////////////////////////////////////

    // architectural register index, r0 reads as zero
    typedef logic [4:0] arch_reg_t;

    // physical register tag, twice the architectural space
    typedef logic [5:0] phys_reg_t;

    // size of the architectural register space
    localparam int NUM_ARCH_REGS = 2 ** $bits(arch_reg_t);

    // the hardwired zero register, never renamed
    localparam arch_reg_t REG_ZERO = '0;

endpackage

/* logic/rob_pkg.sv */
// reorder buffer record types
package rob_pkg;

    //////////////////////////////////////////////////////////////////////
    // buffer entry
    //////////////////////////////////////////////////////////////////////

    // one slot of the reorder buffer
    // flags first, then the payload
    typedef struct packed {
        logic              valid;
        // execution finished, result is in the register file
        logic              complete;
        // entry is a control transfer
        logic              branch;
        // retiring this stops the machine
        logic              halt;
        // set at completion when the prediction was wrong
        logic              mispredict;
        isa_pkg::pc_t      pc;
        // destination, r0 when nothing is written
        isa_pkg::arch_reg_t arch_rd;
        // tag handed out by rename
        isa_pkg::phys_reg_t phys_rd;
        // correct next pc, filled in at completion
        isa_pkg::pc_t      branch_target;
    } rob_entry_t;

    //////////////////////////////////////////////////////////////////////
    // retire record
    //////////////////////////////////////////////////////////////////////

    // what leaves the buffer per lane at retirement
    typedef struct packed {
        logic              valid;
        isa_pkg::pc_t      pc;
        isa_pkg::arch_reg_t arch_rd;
        isa_pkg::phys_reg_t phys_rd;
    } retire_rec_t;

endpackage

/* logic/rob_links.sv */
// links between buffer, retire control and commit map
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// head window, buffer to retire control and back
//////////////////////////////////////////////////////////////////////

interface head_link #(
    parameter int LANES     = 2,
    parameter int ROB_DEPTH = 8
);
    import rob_pkg::*;

    // oldest entry in lane 0
    rob_entry_t [LANES-1:0]                         head_entries;
    // buffer index of each window lane
    logic       [LANES-1:0][$clog2(ROB_DEPTH)-1:0]  head_idxs;
    // entries leaving at the next edge
    logic       [$clog2(LANES+1)-1:0]               retire_count;
    // drop everything at the next edge
    logic                                           flush;

    modport buffer (
        output head_entries,
        output head_idxs,
        input  retire_count,
        input  flush
    );

    modport ctrl (
        input  head_entries,
        input  head_idxs,
        output retire_count,
        output flush
    );
endinterface

//////////////////////////////////////////////////////////////////////
// retire records, retire control to commit map
//////////////////////////////////////////////////////////////////////

interface retire_link #(
    parameter int LANES = 2
);
    import isa_pkg::*;
    import rob_pkg::*;

    retire_rec_t [LANES-1:0] records;
    // mispredicted branch among this cycle's records
    logic                    redirect_valid;
    pc_t                     redirect_pc;

    modport ctrl (
        output records,
        output redirect_valid,
        output redirect_pc
    );

    modport map (
        input records,
        input redirect_valid,
        input redirect_pc
    );
endinterface

/* logic/rob_buffer.sv */
// reorder buffer entry storage
`timescale 1ns/1ps

module rob_buffer #(
    parameter int LANES     = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                                        clock,
    input  logic                                        reset,
    // dispatch, packed from lane 0
    input  logic               [LANES-1:0]              dispatch_valid,
    input  rob_pkg::rob_entry_t [LANES-1:0]             dispatch_entry,
    // completion from execution
    input  logic               [LANES-1:0]              complete_valid,
    input  logic               [LANES-1:0][$clog2(ROB_DEPTH)-1:0] complete_idx,
    input  logic               [LANES-1:0]              complete_mispredict,
    input  isa_pkg::pc_t       [LANES-1:0]              complete_target,
    // allocation feedback to the dispatcher
    output logic               [LANES-1:0][$clog2(ROB_DEPTH)-1:0] alloc_idx,
    output logic               [$clog2(ROB_DEPTH+1)-1:0] free_slots,
    head_link.buffer                                    head
);
    import rob_pkg::*;

    localparam int IDX_W  = $clog2(ROB_DEPTH);
    localparam int CNT_W  = $clog2(ROB_DEPTH + 1);
    localparam int LANE_W = $clog2(LANES + 1);

    // payload storage, the flag fields valid and complete are unused here
    rob_entry_t [ROB_DEPTH-1:0] entries;

    // per-slot control
    logic [ROB_DEPTH-1:0] entry_valid;
    logic [ROB_DEPTH-1:0] entry_done;

    logic [IDX_W-1:0]  head_ptr;
    logic [IDX_W-1:0]  tail_ptr;
    logic [CNT_W-1:0]  free_count;
    logic [LANE_W-1:0] dispatch_count;

    //////////////////////////////////////////////////////////////////////
    // allocation and head window
    //////////////////////////////////////////////////////////////////////

    assign dispatch_count = LANE_W'($countones(dispatch_valid));
    assign free_slots     = free_count;

    // power-of-two depth, wrap is free
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            alloc_idx[i] = tail_ptr + IDX_W'(i);
        end
    end

    always_comb begin
        rob_entry_t win;
        for (int i = 0; i < LANES; i++) begin
            head.head_idxs[i] = head_ptr + IDX_W'(i);
            win               = entries[head.head_idxs[i]];
            // flags come from the control vectors
            win.valid         = entry_valid[head.head_idxs[i]];
            win.complete      = entry_done[head.head_idxs[i]];
            head.head_entries[i] = win;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_done  <= '0;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            free_count  <= CNT_W'(ROB_DEPTH);
        end else if (head.flush) begin
            // mispredict retiring, dispatches this cycle are dropped too
            entry_valid <= '0;
            entry_done  <= '0;
            head_ptr    <= '0;
            tail_ptr    <= '0;
            free_count  <= CNT_W'(ROB_DEPTH);
        end else begin
            // retired prefix leaves
            for (int i = 0; i < LANES; i++) begin
                if (i < head.retire_count) begin
                    entry_valid[head.head_idxs[i]] <= 1'b0;
                    entry_done[head.head_idxs[i]]  <= 1'b0;
                end
            end
            // new entries at the tail
            for (int i = 0; i < LANES; i++) begin
                if (dispatch_valid[i]) begin
                    entry_valid[alloc_idx[i]] <= 1'b1;
                    entry_done[alloc_idx[i]]  <= 1'b0;
                end
            end
            // completions, any order
            for (int i = 0; i < LANES; i++) begin
                if (complete_valid[i]) begin
                    entry_done[complete_idx[i]] <= 1'b1;
                end
            end
            head_ptr   <= head_ptr + IDX_W'(head.retire_count);
            tail_ptr   <= tail_ptr + IDX_W'(dispatch_count);
            free_count <= free_count + CNT_W'(head.retire_count) - CNT_W'(dispatch_count);
        end
    end

    // payload, written at dispatch, branch outcome at completion
    always_ff @(posedge clock) begin
        for (int i = 0; i < LANES; i++) begin
            if (dispatch_valid[i]) begin
                entries[alloc_idx[i]] <= dispatch_entry[i];
            end
        end
        for (int i = 0; i < LANES; i++) begin
            if (complete_valid[i]) begin
                entries[complete_idx[i]].mispredict    <= complete_mispredict[i];
                entries[complete_idx[i]].branch_target <= complete_target[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // handshake checks
    //////////////////////////////////////////////////////////////////////

    // lanes packed from 0 and never more than the dispatcher was offered
    assert property (@(posedge clock) disable iff (reset)
        ((dispatch_valid & (dispatch_valid + 1'b1)) == '0)
        && (CNT_W'(dispatch_count) <= free_count));

    // completion only names a live entry that is still waiting
    for (genvar g = 0; g < LANES; g++) begin : g_complete_chk
        assert property (@(posedge clock) disable iff (reset)
            complete_valid[g] |-> entry_valid[complete_idx[g]]
                                  && !entry_done[complete_idx[g]]);
    end

endmodule

/* logic/retire_ctrl.sv */
// retire decision and halt state
`timescale 1ns/1ps

module retire_ctrl #(
    parameter int LANES = 2
) (
    input  logic      clock,
    input  logic      reset,
    head_link.ctrl    head,
    retire_link.ctrl  retire,
    output logic      halted
);
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int LANE_W = $clog2(LANES + 1);

    logic [LANE_W-1:0] count;
    logic              flush_req;
    logic              halt_req;
    pc_t               target;

    //////////////////////////////////////////////////////////////////////
    // prefix scan over the head window
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic stop;
        stop      = halted;
        count     = '0;
        flush_req = 1'b0;
        halt_req  = 1'b0;
        target    = '0;
        for (int i = 0; i < LANES; i++) begin
            if (!stop && head.head_entries[i].valid && head.head_entries[i].complete) begin
                count = LANE_W'(i + 1);
                // wrong path behind this one so the run stops here
                if (head.head_entries[i].branch && head.head_entries[i].mispredict) begin
                    flush_req = 1'b1;
                    target    = head.head_entries[i].branch_target;
                    stop      = 1'b1;
                end
                if (head.head_entries[i].halt) begin
                    halt_req = 1'b1;
                    stop     = 1'b1;
                end
            end else begin
                // first gap ends the run
                stop = 1'b1;
            end
        end
    end

    assign head.retire_count = count;
    assign head.flush        = flush_req;

    // sticky until reset
    always_ff @(posedge clock) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (halt_req) begin
            halted <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retire records
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            retire.records[i].valid   = (i < count);
            retire.records[i].pc      = head.head_entries[i].pc;
            retire.records[i].arch_rd = head.head_entries[i].arch_rd;
            retire.records[i].phys_rd = head.head_entries[i].phys_rd;
        end
    end

    assign retire.redirect_valid = flush_req;
    assign retire.redirect_pc    = target;

    // the buffer never shows a finished flag on an empty slot
    for (genvar g = 0; g < LANES; g++) begin : g_head_chk
        assert property (@(posedge clock) disable iff (reset)
            head.head_entries[g].complete |-> head.head_entries[g].valid);
    end

    // nothing is left in the window right after a flush
    assert property (@(posedge clock) disable iff (reset)
        head.flush |=> !head.head_entries[0].valid);

endmodule

/* logic/commit_map.sv */
// committed register map and retire outputs
`timescale 1ns/1ps

module commit_map #(
    parameter int LANES = 2
) (
    input  logic                                clock,
    input  logic                                reset,
    retire_link.map                             retire,
    output logic               [LANES-1:0]      retire_valid,
    output isa_pkg::pc_t       [LANES-1:0]      retire_pc,
    output isa_pkg::arch_reg_t [LANES-1:0]      retire_arch_rd,
    output isa_pkg::phys_reg_t [LANES-1:0]      retire_phys_rd,
    output isa_pkg::phys_reg_t [LANES-1:0]      retire_freed_phys,
    output logic                                redirect_valid,
    output isa_pkg::pc_t                        redirect_pc
);
    import isa_pkg::*;

    // committed arch to phys mapping
    phys_reg_t [NUM_ARCH_REGS-1:0] map_q;
    phys_reg_t [NUM_ARCH_REGS-1:0] map_next;
    phys_reg_t [LANES-1:0]         freed;

    //////////////////////////////////////////////////////////////////////
    // lane by lane update where younger lanes see older writes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        map_next = map_q;
        for (int i = 0; i < LANES; i++) begin
            freed[i] = retire.records[i].phys_rd;
            if (retire.records[i].valid && retire.records[i].arch_rd != REG_ZERO) begin
                // old tag is dead once this one commits
                freed[i] = map_next[retire.records[i].arch_rd];
                map_next[retire.records[i].arch_rd] = retire.records[i].phys_rd;
            end
        end
    end

    // identity after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < NUM_ARCH_REGS; r++) begin
                map_q[r] <= phys_reg_t'(r);
            end
            retire_valid   <= '0;
            redirect_valid <= 1'b0;
        end else begin
            map_q          <= map_next;
            redirect_valid <= retire.redirect_valid;
            for (int i = 0; i < LANES; i++) begin
                retire_valid[i] <= retire.records[i].valid;
            end
        end
    end

    // payload outputs
    always_ff @(posedge clock) begin
        for (int i = 0; i < LANES; i++) begin
            retire_pc[i]         <= retire.records[i].pc;
            retire_arch_rd[i]    <= retire.records[i].arch_rd;
            retire_phys_rd[i]    <= retire.records[i].phys_rd;
            retire_freed_phys[i] <= freed[i];
        end
        redirect_pc <= retire.redirect_pc;
    end

endmodule

/* logic/rob_top.sv */
// reorder buffer retire block
`timescale 1ns/1ps

module rob_top #(
    parameter int LANES     = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                                        clock,
    input  logic                                        reset,
    // dispatch
    input  logic                [LANES-1:0]             dispatch_valid,
    input  rob_pkg::rob_entry_t [LANES-1:0]             dispatch_entry,
    output logic                [LANES-1:0][$clog2(ROB_DEPTH)-1:0] alloc_idx,
    output logic                [$clog2(ROB_DEPTH+1)-1:0] free_slots,
    // completion
    input  logic                [LANES-1:0]             complete_valid,
    input  logic                [LANES-1:0][$clog2(ROB_DEPTH)-1:0] complete_idx,
    input  logic                [LANES-1:0]             complete_mispredict,
    input  isa_pkg::pc_t        [LANES-1:0]             complete_target,
    // retire
    output logic                [LANES-1:0]             retire_valid,
    output isa_pkg::pc_t        [LANES-1:0]             retire_pc,
    output isa_pkg::arch_reg_t  [LANES-1:0]             retire_arch_rd,
    output isa_pkg::phys_reg_t  [LANES-1:0]             retire_phys_rd,
    output isa_pkg::phys_reg_t  [LANES-1:0]             retire_freed_phys,
    output logic                                        redirect_valid,
    output isa_pkg::pc_t                                redirect_pc,
    output logic                                        halted
);

    head_link #(.LANES(LANES), .ROB_DEPTH(ROB_DEPTH)) i_head_link ();
    retire_link #(.LANES(LANES)) i_retire_link ();

    // storage and pointers
    rob_buffer #(.LANES(LANES), .ROB_DEPTH(ROB_DEPTH)) i_rob_buffer (
        .clock               (clock),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_entry      (dispatch_entry),
        .complete_valid      (complete_valid),
        .complete_idx        (complete_idx),
        .complete_mispredict (complete_mispredict),
        .complete_target     (complete_target),
        .alloc_idx           (alloc_idx),
        .free_slots          (free_slots),
        .head                (i_head_link.buffer)
    );

    // how many leave, flush and halt
    retire_ctrl #(.LANES(LANES)) i_retire_ctrl (
        .clock  (clock),
        .reset  (reset),
        .head   (i_head_link.ctrl),
        .retire (i_retire_link.ctrl),
        .halted (halted)
    );

    // committed map, registered outputs
    commit_map #(.LANES(LANES)) i_commit_map (
        .clock             (clock),
        .reset             (reset),
        .retire            (i_retire_link.map),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_arch_rd    (retire_arch_rd),
        .retire_phys_rd    (retire_phys_rd),
        .retire_freed_phys (retire_freed_phys),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

/* testbench/rob_ref.svh */
// retire reference model
`ifndef ROB_REF_SVH
`define ROB_REF_SVH

// shadow buffer and pointers
rob_entry_t m_entry [ROB_DEPTH];
int         m_head;
int         m_tail;
int         m_free;
bit         m_halted;
phys_reg_t  m_map [NUM_ARCH_REGS];

// registered outputs expected after the current edge
retire_rec_t exp_rec [LANES];
phys_reg_t   exp_freed [LANES];
bit          exp_redirect;
pc_t         exp_redirect_pc;
int          exp_count;
bit          exp_halt_req;

function automatic void model_reset();
    for (int s = 0; s < ROB_DEPTH; s++) begin
        m_entry[s] = '0;
    end
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
        m_map[r] = phys_reg_t'(r);
    end
    for (int i = 0; i < LANES; i++) begin
        exp_rec[i]   = '0;
        exp_freed[i] = '0;
    end
    m_head          = 0;
    m_tail          = 0;
    m_free          = ROB_DEPTH;
    m_halted        = 1'b0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = '0;
    exp_count       = 0;
    exp_halt_req    = 1'b0;
endfunction

// retire records, freed tags and redirect for this cycle
// also commits the map, oldest lane first
function automatic void compute_retire();
    bit         stop;
    rob_entry_t e;
    stop            = m_halted;
    exp_count       = 0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = '0;
    exp_halt_req    = 1'b0;
    for (int i = 0; i < LANES; i++) begin
        e                  = m_entry[(m_head + i) % ROB_DEPTH];
        exp_rec[i].valid   = 1'b0;
        exp_rec[i].pc      = e.pc;
        exp_rec[i].arch_rd = e.arch_rd;
        exp_rec[i].phys_rd = e.phys_rd;
        // r0 frees its own tag
        exp_freed[i]       = e.phys_rd;
        if (!stop && e.valid && e.complete) begin
            exp_count        = i + 1;
            exp_rec[i].valid = 1'b1;
            if (e.arch_rd != REG_ZERO) begin
                exp_freed[i]      = m_map[e.arch_rd];
                m_map[e.arch_rd]  = e.phys_rd;
            end
            if (e.branch && e.mispredict) begin
                exp_redirect    = 1'b1;
                exp_redirect_pc = e.branch_target;
                stop            = 1'b1;
            end
            if (e.halt) begin
                exp_halt_req = 1'b1;
                stop         = 1'b1;
            end
        end else begin
            stop = 1'b1;
        end
    end
endfunction

// buffer update at the edge, from the inputs sampled there
function automatic void model_step();
    int n;
    n = 0;
    if (exp_redirect) begin
        // everything goes, dispatches too
        for (int s = 0; s < ROB_DEPTH; s++) begin
            m_entry[s].valid    = 1'b0;
            m_entry[s].complete = 1'b0;
        end
        m_head = 0;
        m_tail = 0;
        m_free = ROB_DEPTH;
    end else begin
        for (int i = 0; i < exp_count; i++) begin
            m_entry[(m_head + i) % ROB_DEPTH].valid    = 1'b0;
            m_entry[(m_head + i) % ROB_DEPTH].complete = 1'b0;
        end
        for (int i = 0; i < LANES; i++) begin
            if (dispatch_valid[i]) begin
                m_entry[(m_tail + i) % ROB_DEPTH]          = dispatch_entry[i];
                m_entry[(m_tail + i) % ROB_DEPTH].valid    = 1'b1;
                m_entry[(m_tail + i) % ROB_DEPTH].complete = 1'b0;
                n++;
            end
        end
        for (int i = 0; i < LANES; i++) begin
            if (complete_valid[i]) begin
                m_entry[complete_idx[i]].complete      = 1'b1;
                m_entry[complete_idx[i]].mispredict    = complete_mispredict[i];
                m_entry[complete_idx[i]].branch_target = complete_target[i];
            end
        end
        m_head = (m_head + exp_count) % ROB_DEPTH;
        m_tail = (m_tail + n) % ROB_DEPTH;
        m_free = m_free + exp_count - n;
    end
    if (exp_halt_req) begin
        m_halted = 1'b1;
    end
endfunction

`endif

/* testbench/tb_rob_top.sv */
// retire block testbench
`timescale 1ns/1ps

module tb_rob_top;
    import isa_pkg::*;
    import rob_pkg::*;

    localparam int LANES     = 2;
    localparam int ROB_DEPTH = 8;
    localparam int IDX_W     = $clog2(ROB_DEPTH);
    localparam int CNT_W     = $clog2(ROB_DEPTH + 1);

    // test modes
    localparam int MODE_IDLE   = 0;
    localparam int MODE_PLAIN  = 1;
    localparam int MODE_BRANCH = 2;
    localparam int MODE_HALT   = 3;

    // cycles per test, reset included
    localparam int RESET_CYCLES = 5;
    localparam int STIM_CYCLES  = 4 * RESET_CYCLES + 10 + 300 + 300 + 100;
    localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] count_t;

    logic                              clock;
    logic                              reset;
    logic       [LANES-1:0]            dispatch_valid;
    rob_entry_t [LANES-1:0]            dispatch_entry;
    idx_t       [LANES-1:0]            alloc_idx;
    count_t                            free_slots;
    logic       [LANES-1:0]            complete_valid;
    idx_t       [LANES-1:0]            complete_idx;
    logic       [LANES-1:0]            complete_mispredict;
    pc_t        [LANES-1:0]            complete_target;
    logic       [LANES-1:0]            retire_valid;
    pc_t        [LANES-1:0]            retire_pc;
    arch_reg_t  [LANES-1:0]            retire_arch_rd;
    phys_reg_t  [LANES-1:0]            retire_phys_rd;
    phys_reg_t  [LANES-1:0]            retire_freed_phys;
    logic                              redirect_valid;
    pc_t                               redirect_pc;
    logic                              halted;

    `include "rob_ref.svh"

    // run bookkeeping
    string       cur_test;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          retired_seen;
    int          flushes_seen;
    bit          started;
    logic [31:0] rng_state;
    pc_t         next_pc;
    int          seq;

    rob_top #(.LANES(LANES), .ROB_DEPTH(ROB_DEPTH)) i_rob_top (.*);

    //////////////////////////////////////////////////////////////////////
    // clock and timeout
    //////////////////////////////////////////////////////////////////////

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout, run still going after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic compare_rec(string what, retire_rec_t e, retire_rec_t a);
        checks++;
        // payload only matters on a valid lane
        if (e.valid !== a.valid || (e.valid && e !== a)) begin
            errors++;
            $display("Fail %s %s expected %h actual %h", cur_test, what, e, a);
        end
    endtask

    task automatic compare_tag(string what, phys_reg_t e, phys_reg_t a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s %s expected %0d actual %0d", cur_test, what, e, a);
        end
    endtask

    task automatic compare_pc(string what, pc_t e, pc_t a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s %s expected %h actual %h", cur_test, what, e, a);
        end
    endtask

    task automatic compare_count(string what, count_t e, count_t a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s %s expected %0d actual %0d", cur_test, what, e, a);
        end
    endtask

    task automatic compare_idx(string what, idx_t e, idx_t a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s %s expected %0d actual %0d", cur_test, what, e, a);
        end
    endtask

    task automatic compare_flag(string what, logic e, logic a);
        checks++;
        if (e !== a) begin
            errors++;
            $display("Fail %s %s expected %b actual %b", cur_test, what, e, a);
        end
    endtask

    // outputs settle long before the falling edge
    always @(negedge clock) begin
        retire_rec_t act;
        if (started) begin
            for (int i = 0; i < LANES; i++) begin
                act.valid   = retire_valid[i];
                act.pc      = retire_pc[i];
                act.arch_rd = retire_arch_rd[i];
                act.phys_rd = retire_phys_rd[i];
                compare_rec($sformatf("retire lane %0d", i), exp_rec[i], act);
                if (exp_rec[i].valid && retire_valid[i]) begin
                    compare_tag($sformatf("freed lane %0d", i), exp_freed[i],
                                retire_freed_phys[i]);
                    retired_seen++;
                end
                compare_idx($sformatf("alloc_idx lane %0d", i),
                            idx_t'((m_tail + i) % ROB_DEPTH), alloc_idx[i]);
            end
            compare_flag("redirect_valid", exp_redirect, redirect_valid);
            if (exp_redirect && redirect_valid) begin
                compare_pc("redirect_pc", exp_redirect_pc, redirect_pc);
                flushes_seen++;
            end
            compare_count("free_slots", count_t'(m_free), free_slots);
            compare_flag("halted", m_halted, halted);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // one edge, model follows what the DUT sampled
    task automatic tick();
        @(posedge clock);
        if (reset) begin
            model_reset();
            started = 1'b1;
        end else begin
            compute_retire();
            model_step();
        end
    endtask

    task automatic drive_idle();
        dispatch_valid      <= '0;
        dispatch_entry      <= '0;
        complete_valid      <= '0;
        complete_idx        <= '0;
        complete_mispredict <= '0;
        complete_target     <= '0;
    endtask

    task automatic drive_random(input int mode);
        int                     n;
        int                     k;
        int                     waiting[$];
        logic       [LANES-1:0] dv;
        rob_entry_t [LANES-1:0] de;
        logic       [LANES-1:0] cv;
        idx_t       [LANES-1:0] cidx;
        logic       [LANES-1:0] cmis;
        pc_t        [LANES-1:0] ctgt;
        n  = xorshift() % (LANES + 1);
        // never more than the buffer offers
        if (n > m_free) begin
            n = m_free;
        end
        dv = '0;
        de = '0;
        for (int i = 0; i < n; i++) begin
            dv[i]         = 1'b1;
            de[i].pc      = next_pc;
            // small register range makes same-cycle collisions likely
            de[i].arch_rd = arch_reg_t'(xorshift() % 8);
            de[i].phys_rd = phys_reg_t'(xorshift());
            de[i].branch  = (mode == MODE_BRANCH) && (xorshift() % 4 == 0);
            de[i].halt    = (mode == MODE_HALT) && (seq == 9);
            next_pc       = next_pc + 4;
            seq++;
        end
        // completion picks waiting entries in random order
        for (int s = 0; s < ROB_DEPTH; s++) begin
            if (m_entry[s].valid && !m_entry[s].complete) begin
                waiting.push_back(s);
            end
        end
        cv   = '0;
        cidx = '0;
        cmis = '0;
        ctgt = '0;
        for (int i = 0; i < LANES; i++) begin
            if (waiting.size() > 0 && xorshift() % 3 != 0) begin
                k       = xorshift() % waiting.size();
                cv[i]   = 1'b1;
                cidx[i] = idx_t'(waiting[k]);
                cmis[i] = m_entry[waiting[k]].branch && (xorshift() % 3 == 0);
                ctgt[i] = xorshift() & 32'hffff_fffc;
                waiting.delete(k);
            end
        end
        dispatch_valid      <= dv;
        dispatch_entry      <= de;
        complete_valid      <= cv;
        complete_idx        <= cidx;
        complete_mispredict <= cmis;
        complete_target     <= ctgt;
    endtask

    task automatic apply_reset();
        reset <= 1'b1;
        drive_idle();
        repeat (RESET_CYCLES) begin
            tick();
        end
        reset <= 1'b0;
    endtask

    task automatic run_test(input string name, input int mode, input int length);
        int start_errors;
        cur_test     = name;
        start_errors = errors;
        apply_reset();
        retired_seen = 0;
        flushes_seen = 0;
        seq          = 0;
        next_pc      = 32'h0000_1000;
        repeat (length) begin
            tick();
            if (mode == MODE_IDLE) begin
                drive_idle();
            end else begin
                drive_random(mode);
            end
        end
        // the run must actually reach the behavior under test
        if (mode == MODE_PLAIN && retired_seen == 0) begin
            errors++;
            $display("%s: no instruction retired in the whole run", name);
        end
        if (mode == MODE_BRANCH && flushes_seen == 0) begin
            errors++;
            $display("%s: no mispredict flush was seen", name);
        end
        if (mode == MODE_HALT && halted !== 1'b1) begin
            errors++;
            $display("%s: the halt never reached retirement", name);
        end
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", name, errors - start_errors);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        reset     = 1'b1;
        rng_state = 32'd71054;
        started   = 1'b0;
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        next_pc   = '0;
        seq       = 0;
        drive_idle();
        run_test("reset_state", MODE_IDLE, 10);
        run_test("random_inorder", MODE_PLAIN, 300);
        run_test("mispredict_flush", MODE_BRANCH, 300);
        run_test("halt", MODE_HALT, 100);
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+testbench
logic/isa_pkg.sv
logic/rob_pkg.sv
logic/rob_links.sv
logic/rob_buffer.sv
logic/retire_ctrl.sv
logic/commit_map.sv
logic/rob_top.sv
testbench/tb_rob_top.sv

/* Bender.yml */
package:
  name: rob_retire

sources:
  - logic/isa_pkg.sv
  - logic/rob_pkg.sv
  - logic/rob_links.sv
  - logic/rob_buffer.sv
  - logic/retire_ctrl.sv
  - logic/commit_map.sv
  - logic/rob_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_rob_top.sv
